// ==== source/cnn_rx_pkg.sv ====
// Receiver widths, class and channel counts, bias ROM addresses and bus structs
package cnn_rx_pkg;

    // Lane geometry fixed by the MAC array
    localparam int NUM_CH      = 16;
    localparam int ACC_W       = 20;
    localparam int DATA_W      = 16;

    // Classifier and pooled map sizes
    localparam int NUM_CLASSES = 10;
    localparam int POOL_ADDR_W = 8;
    localparam int CLASS_W     = 4;

    // Bias ROM word per layer
    localparam int BIAS_ADDR_W = 4;
    localparam logic [BIAS_ADDR_W-1:0] BIAS_ADDR_CONV  = 4'd0;
    localparam logic [BIAS_ADDR_W-1:0] BIAS_ADDR_CLASS = 4'd1;

    // One result beat from the MAC array
    typedef struct packed {
        logic                          valid;
        logic [NUM_CH-1:0][ACC_W-1:0]  acc;
    } mac_beat_t;

    // Lane k holds the bias of channel k or class k
    typedef logic [NUM_CH-1:0][DATA_W-1:0] bias_word_t;

    // Pooled pixel write, all channels at one address
    typedef struct packed {
        logic                          en;
        logic [POOL_ADDR_W-1:0]        addr;
        logic [NUM_CH-1:0][DATA_W-1:0] data;
    } fmap_wr_t;

    // Class scores, each one read as signed
    typedef logic [NUM_CLASSES-1:0][DATA_W-1:0] score_vec_t;

    typedef struct packed {
        logic               valid;
        logic [CLASS_W-1:0] digit;
    } digit_t;

endpackage

// ==== source/rx_sequencer.sv ====
// Layer phase FSM with bias address selection and beat routing
module rx_sequencer
    import cnn_rx_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  mac_beat_t              mac_i,
    input  logic                   frame_done_i,
    input  logic                   scores_full_i,
    output mac_beat_t              conv_beat_o,
    output mac_beat_t              fc_beat_o,
    output logic [BIAS_ADDR_W-1:0] bias_addr_o,
    output logic                   conv_phase_o
);

    typedef enum logic [1:0] {
        ST_CONV,
        ST_FC,
        ST_WAIT
    } rx_state_e;

    rx_state_e state_q;
    rx_state_e state_d;
    logic      conv_phase_q;
    logic      conv_phase_d;

    // Phase flips on the handover edge, WAIT absorbs the gap cycle
    always_comb
    begin
        state_d      = state_q;
        conv_phase_d = conv_phase_q;
        case (state_q)
            ST_CONV:
            begin
                if (frame_done_i)
                begin
                    state_d      = ST_WAIT;
                    conv_phase_d = 1'b0;
                end
            end
            ST_FC:
            begin
                if (scores_full_i)
                begin
                    state_d      = ST_WAIT;
                    conv_phase_d = 1'b1;
                end
            end
            default:
            begin
                state_d = conv_phase_q ? ST_CONV : ST_FC;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_q      <= ST_CONV;
            conv_phase_q <= 1'b1;
        end
        else
        begin
            state_q      <= state_d;
            conv_phase_q <= conv_phase_d;
        end
    end

    // Payload goes to both consumers, only one sees valid
    always_comb
    begin
        conv_beat_o       = mac_i;
        fc_beat_o         = mac_i;
        conv_beat_o.valid = mac_i.valid && (state_q == ST_CONV);
        fc_beat_o.valid   = mac_i.valid && (state_q == ST_FC);
    end

    assign bias_addr_o  = conv_phase_q ? BIAS_ADDR_CONV : BIAS_ADDR_CLASS;
    assign conv_phase_o = conv_phase_q;

    // MAC array must stay idle for the cycle following a layer handover
    a_no_beat_in_gap: assert property (
        @(posedge clk) disable iff (rst)
        (frame_done_i || scores_full_i) |=> !mac_i.valid
    );

endmodule

// ==== source/pool_window.sv ====
// Bias and saturating ReLU per lane, line buffer, 2x2 average pooling and pooled write port
module pool_window
    import cnn_rx_pkg::*;
#(
    parameter int FMAP_DIM = 28
)
(
    input  logic       clk,
    input  logic       rst,
    input  mac_beat_t  beat_i,
    input  bias_word_t bias_i,
    output fmap_wr_t   fmap_wr_o,
    output logic       frame_done_o
);

    localparam int POS_W   = $clog2(FMAP_DIM);
    localparam int SAT_MAX = (1 << (DATA_W - 1)) - 1;

    typedef logic [NUM_CH-1:0][DATA_W-1:0] pix_t;

    logic [POS_W-1:0]       x_q;
    logic [POS_W-1:0]       y_q;
    pix_t                   line_q [FMAP_DIM+1];
    pix_t                   pix_act;
    pix_t                   pool_avg;
    logic                   at_pool;
    logic                   last_pix;
    logic [POOL_ADDR_W-1:0] pool_addr;
    logic                   wr_en_q;
    logic [POOL_ADDR_W-1:0] wr_addr_q;
    pix_t                   wr_data_q;
    logic                   done_q;

    // Accumulator plus sign extended bias, clamped to [0, SAT_MAX]
    function automatic logic [DATA_W-1:0] bias_relu(
        input logic [ACC_W-1:0]  acc,
        input logic [DATA_W-1:0] bias
    );
        logic signed [ACC_W:0] sum;
        sum = $signed({acc[ACC_W-1], acc})
            + $signed({{(ACC_W - DATA_W + 1){bias[DATA_W-1]}}, bias});
        if (sum < 0)
            return '0;
        if (sum > SAT_MAX)
            return DATA_W'(SAT_MAX);
        return sum[DATA_W-1:0];
    endfunction

    // Floor of the mean, inputs are never negative after ReLU
    function automatic logic [DATA_W-1:0] avg4(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b,
        input logic [DATA_W-1:0] c,
        input logic [DATA_W-1:0] d
    );
        logic [DATA_W+1:0] total;
        total = {2'b00, a} + {2'b00, b} + {2'b00, c} + {2'b00, d};
        return total[DATA_W+1:2];
    endfunction

    // line_q[0] is the left pixel, the far end holds the row above
    always_comb
    begin
        for (int k = 0; k < NUM_CH; k++)
        begin
            pix_act[k]  = bias_relu(beat_i.acc[k], bias_i[k]);
            pool_avg[k] = avg4(pix_act[k], line_q[0][k],
                               line_q[FMAP_DIM-1][k], line_q[FMAP_DIM][k]);
        end
    end

    assign at_pool   = x_q[0] && y_q[0];
    assign last_pix  = (x_q == POS_W'(FMAP_DIM - 1)) && (y_q == POS_W'(FMAP_DIM - 1));
    assign pool_addr = POOL_ADDR_W'((int'(y_q) / 2) * (FMAP_DIM / 2) + int'(x_q) / 2);

    // Raster position and write strobes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            x_q     <= '0;
            y_q     <= '0;
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            wr_en_q <= beat_i.valid && at_pool;
            done_q  <= beat_i.valid && last_pix;
            if (beat_i.valid)
            begin
                if (x_q == POS_W'(FMAP_DIM - 1))
                begin
                    x_q <= '0;
                    y_q <= (y_q == POS_W'(FMAP_DIM - 1)) ? '0 : y_q + 1'b1;
                end
                else
                begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_i.valid)
        begin
            line_q[0] <= pix_act;
            for (int i = 1; i <= FMAP_DIM; i++)
            begin
                line_q[i] <= line_q[i-1];
            end
        end
        if (beat_i.valid && at_pool)
        begin
            wr_addr_q <= pool_addr;
            wr_data_q <= pool_avg;
        end
    end

    assign fmap_wr_o    = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
    assign frame_done_o = done_q;

    // Windows must tile the map exactly
    a_even_dim: assert property (@(posedge clk) (FMAP_DIM % 2) == 0);

endmodule

// ==== source/score_bank.sv ====
// Biased class score register file with full-set pulse
module score_bank
    import cnn_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  mac_beat_t  beat_i,
    input  bias_word_t bias_i,
    output score_vec_t scores_o,
    output logic       scores_full_o
);

    logic [CLASS_W-1:0] cls_q;
    logic               full_q;
    score_vec_t         scores_q;

    // Class index of the next beat
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cls_q  <= '0;
            full_q <= 1'b0;
        end
        else
        begin
            full_q <= 1'b0;
            if (beat_i.valid)
            begin
                if (cls_q == CLASS_W'(NUM_CLASSES - 1))
                begin
                    cls_q  <= '0;
                    full_q <= 1'b1;
                end
                else
                begin
                    cls_q <= cls_q + 1'b1;
                end
            end
        end
    end

    // Score wraps at DATA_W bits, lane 0 carries the class result
    always_ff @(posedge clk)
    begin
        if (beat_i.valid)
        begin
            scores_q[cls_q] <= beat_i.acc[0][DATA_W-1:0] + bias_i[cls_q];
        end
    end

    assign scores_o      = scores_q;
    assign scores_full_o = full_q;

    a_cls_range: assert property (
        @(posedge clk) disable iff (rst)
        cls_q <= CLASS_W'(NUM_CLASSES - 1)
    );

endmodule

// ==== source/argmax_tree.sv ====
// Four stage pipelined signed arg-max over the class scores
module argmax_tree
    import cnn_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  score_vec_t scores_i,
    input  logic       start_i,
    output digit_t     digit_o
);

    logic [CLASS_W-1:0] s1_idx [5];
    logic [CLASS_W-1:0] s2_idx [2];
    logic [CLASS_W-1:0] s2_hi;
    logic [CLASS_W-1:0] s3_idx;
    logic [CLASS_W-1:0] s3_hi;
    logic [CLASS_W-1:0] s4_idx;
    logic [3:0]         vld_q;

    // Higher index wins a tie
    function automatic logic [CLASS_W-1:0] pick(
        input score_vec_t         s,
        input logic [CLASS_W-1:0] lo,
        input logic [CLASS_W-1:0] hi
    );
        return ($signed(s[lo]) > $signed(s[hi])) ? lo : hi;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            vld_q <= '0;
        end
        else
        begin
            vld_q <= {vld_q[2:0], start_i};
        end
    end

    always_ff @(posedge clk)
    begin
        // Stage 1, adjacent pairs
        for (int p = 0; p < 5; p++)
        begin
            s1_idx[p] <= pick(scores_i, CLASS_W'(2 * p), CLASS_W'(2 * p + 1));
        end
        // Stage 2, classes 8/9 ride along for the last compare
        s2_idx[0] <= pick(scores_i, s1_idx[0], s1_idx[1]);
        s2_idx[1] <= pick(scores_i, s1_idx[2], s1_idx[3]);
        s2_hi     <= s1_idx[4];
        // Stage 3
        s3_idx <= pick(scores_i, s2_idx[0], s2_idx[1]);
        s3_hi  <= s2_hi;
        // Stage 4
        s4_idx <= pick(scores_i, s3_idx, s3_hi);
    end

    assign digit_o = '{valid: vld_q[3], digit: s4_idx};

endmodule

// ==== source/cnn_receiver.sv ====
// Receiver top level with sequencer, pooling, score bank and arg-max
module cnn_receiver
    import cnn_rx_pkg::*;
#(
    parameter int FMAP_DIM = 28
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  mac_beat_t              mac_i,
    input  bias_word_t             bias_q_i,
    output logic [BIAS_ADDR_W-1:0] bias_addr_o,
    output fmap_wr_t               fmap_wr_o,
    output digit_t                 digit_o,
    output logic                   conv_phase_o
);

    mac_beat_t  conv_beat;
    mac_beat_t  fc_beat;
    logic       frame_done;
    score_vec_t scores;
    logic       scores_full;

    rx_sequencer rx_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .mac_i         (mac_i),
        .frame_done_i  (frame_done),
        .scores_full_i (scores_full),
        .conv_beat_o   (conv_beat),
        .fc_beat_o     (fc_beat),
        .bias_addr_o   (bias_addr_o),
        .conv_phase_o  (conv_phase_o)
    );

    // Convolution path
    pool_window #(
        .FMAP_DIM (FMAP_DIM)
    ) pool_window_i (
        .clk          (clk),
        .rst          (rst),
        .beat_i       (conv_beat),
        .bias_i       (bias_q_i),
        .fmap_wr_o    (fmap_wr_o),
        .frame_done_o (frame_done)
    );

    // Classifier path
    score_bank score_bank_i (
        .clk           (clk),
        .rst           (rst),
        .beat_i        (fc_beat),
        .bias_i        (bias_q_i),
        .scores_o      (scores),
        .scores_full_o (scores_full)
    );

    argmax_tree argmax_tree_i (
        .clk      (clk),
        .rst      (rst),
        .scores_i (scores),
        .start_i  (scores_full),
        .digit_o  (digit_o)
    );

endmodule

// ==== sim/tb_model.svh ====
// Reference functions for the saturating ReLU, 2x2 floor average, arg-max and the LCG
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Signed accumulator plus signed bias, clamped to 0..32767
function automatic logic [DATA_W-1:0] clamp_relu(
    input logic [ACC_W-1:0]  acc,
    input logic [DATA_W-1:0] bias
);
    int a;
    int b;
    int s;
    a = $signed(acc);
    b = $signed(bias);
    s = a + b;
    if (s < 0)
        return '0;
    if (s > 32767)
        return DATA_W'(32767);
    return DATA_W'(s);
endfunction

// Inputs are never negative after ReLU
function automatic logic [DATA_W-1:0] floor_avg(input int a, input int b, input int c,
                                                input int d);
    return DATA_W'((a + b + c + d) / 4);
endfunction

// Highest signed score, ties go to the higher index
function automatic logic [CLASS_W-1:0] best_class(input score_vec_t s);
    int best;
    best = 0;
    for (int k = 1; k < NUM_CLASSES; k++)
    begin
        if ($signed(s[k]) >= $signed(s[best]))
            best = k;
    end
    return CLASS_W'(best);
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== sim/tb_cnn_receiver.sv ====
// Testbench for the CNN receiver with bias ROM model, directed tests and output monitor
module tb_cnn_receiver
    import cnn_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FMAP_DIM    = 8;
    localparam int PIXELS      = FMAP_DIM * FMAP_DIM;
    localparam int POOLED      = PIXELS / 4;
    localparam int FRAMES      = 5;
    localparam int CLASS_SETS  = 5;
    localparam int TOTAL_BEATS = FRAMES * PIXELS + CLASS_SETS * NUM_CLASSES;
    localparam int TIMEOUT     = TOTAL_BEATS * 4 + 200;

    logic                   clk = 1'b0;
    logic                   rst;
    mac_beat_t              mac;
    bias_word_t             bias_q;
    logic [BIAS_ADDR_W-1:0] bias_addr;
    fmap_wr_t               fmap_wr;
    digit_t                 digit;
    logic                   conv_phase;

    bias_word_t             bias_rom [1 << BIAS_ADDR_W];
    logic [ACC_W-1:0]       frame_acc [PIXELS][NUM_CH];
    logic [DATA_W-1:0]      act [PIXELS][NUM_CH];
    logic [31:0]            seed;
    int                     cycle = 0;
    int                     wr_count = 0;
    logic                   phase_pending = 1'b0;
    fmap_wr_t               exp_wr [$];
    logic [CLASS_W-1:0]     exp_digit [$];
    int                     digit_due [$];

    `include "tb_model.svh"

    cnn_receiver #(
        .FMAP_DIM (FMAP_DIM)
    ) cnn_receiver_i (
        .clk          (clk),
        .rst          (rst),
        .mac_i        (mac),
        .bias_q_i     (bias_q),
        .bias_addr_o  (bias_addr),
        .fmap_wr_o    (fmap_wr),
        .digit_o      (digit),
        .conv_phase_o (conv_phase)
    );

    // Asynchronous-read bias ROM
    assign bias_q = bias_rom[bias_addr];

    initial
    begin
        forever #5 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [NUM_CH*DATA_W-1:0] got,
                         input logic [NUM_CH*DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            mac <= '0;
        end
    endtask

    // Expected pooled writes of the frame held in frame_acc
    task automatic queue_frame_writes(input bias_word_t bias);
        fmap_wr_t w;
        int       p;
        int       n;
        n = 0;
        for (int i = 0; i < PIXELS; i++)
        begin
            for (int k = 0; k < NUM_CH; k++)
                act[i][k] = clamp_relu(frame_acc[i][k], bias[k]);
        end
        for (int y = 1; y < FMAP_DIM; y += 2)
        begin
            for (int x = 1; x < FMAP_DIM; x += 2)
            begin
                p      = y * FMAP_DIM + x;
                w.en   = 1'b1;
                // Pooled pixels are written in raster order from address 0
                w.addr = POOL_ADDR_W'(n);
                n      = n + 1;
                for (int k = 0; k < NUM_CH; k++)
                    w.data[k] = floor_avg(act[p][k], act[p-1][k], act[p-FMAP_DIM][k],
                                          act[p-FMAP_DIM-1][k]);
                exp_wr.push_back(w);
            end
        end
    endtask

    // Two idle cycles cover the handover gap
    task automatic send_frame(input bias_word_t bias, input logic idles);
        mac_beat_t b;
        bias_rom[BIAS_ADDR_CONV] <= bias;
        queue_frame_writes(bias);
        for (int p = 0; p < PIXELS; p++)
        begin
            b.valid = 1'b1;
            for (int k = 0; k < NUM_CH; k++)
                b.acc[k] = frame_acc[p][k];
            @(posedge clk);
            mac <= b;
            if (idles)
            begin
                seed = lcg_next(seed);
                drive_idle(int'(seed[17:16]));
            end
        end
        drive_idle(2);
    endtask

    task automatic send_class_set(input score_vec_t raw, input bias_word_t bias);
        score_vec_t score;
        mac_beat_t  b;
        for (int k = 0; k < NUM_CLASSES; k++)
            score[k] = raw[k] + bias[k];
        exp_digit.push_back(best_class(score));
        bias_rom[BIAS_ADDR_CLASS] <= bias;
        for (int k = 0; k < NUM_CLASSES; k++)
        begin
            b.valid = 1'b1;
            for (int j = 1; j < NUM_CH; j++)
                b.acc[j] = ACC_W'(37 * j + k);
            // Upper bits of lane 0 must not reach the score
            b.acc[0] = {(ACC_W - DATA_W)'(k + 5), raw[k]};
            @(posedge clk);
            mac <= b;
        end
        digit_due.push_back(cycle + 6);
        drive_idle(2);
    endtask

    task automatic send_random_class_set();
        score_vec_t raw;
        bias_word_t bias;
        for (int k = 0; k < NUM_CH; k++)
        begin
            seed    = lcg_next(seed);
            bias[k] = seed[31:16];
            if (k < NUM_CLASSES)
                raw[k] = seed[23:8];
        end
        send_class_set(raw, bias);
    endtask

    // Sums land below zero, in range and above saturation in similar shares
    task automatic fill_random_frame(output bias_word_t bias);
        for (int k = 0; k < NUM_CH; k++)
        begin
            seed    = lcg_next(seed);
            bias[k] = DATA_W'($signed(seed[31:22]));
        end
        for (int p = 0; p < PIXELS; p++)
        begin
            for (int k = 0; k < NUM_CH; k++)
            begin
                seed            = lcg_next(seed);
                frame_acc[p][k] = ACC_W'($signed(seed[31:15]));
            end
        end
    endtask

    task automatic verify_reset_state();
        repeat (4)
        begin
            @(negedge clk);
            check("fmap_wr_o.en", fmap_wr.en, 1'b0);
            check("digit_o.valid", digit.valid, 1'b0);
            check("conv_phase_o", conv_phase, 1'b1);
            check("bias_addr_o", bias_addr, BIAS_ADDR_CONV);
        end
    endtask

    task automatic constant_frame_writes();
        for (int p = 0; p < PIXELS; p++)
        begin
            for (int k = 0; k < NUM_CH; k++)
                frame_acc[p][k] = ACC_W'(1000 * k + 37);
        end
        send_frame('0, 1'b0);
        send_random_class_set();
    endtask

    task automatic relu_pool_extremes();
        bias_word_t bias;
        int         x;
        int         y;
        for (int p = 0; p < PIXELS; p++)
        begin
            x = p % FMAP_DIM;
            y = p / FMAP_DIM;
            for (int k = 0; k < NUM_CH; k++)
            begin
                case (k % 4)
                    0: frame_acc[p][k] = ACC_W'(-(500 + p));
                    1: frame_acc[p][k] = ACC_W'(40000 + 100 * p);
                    // Checkerboard of negative and positive pixels inside each window
                    2: frame_acc[p][k] = ((x + y) % 2 == 1) ? ACC_W'(-(300 + p))
                                                            : ACC_W'(900 + 13 * p);
                    default: frame_acc[p][k] = ACC_W'(32600 + 3 * p);
                endcase
            end
        end
        for (int k = 0; k < NUM_CH; k++)
            bias[k] = (k % 4 == 0) ? 16'd530 : (k % 4 == 1) ? 16'(-1000)
                    : (k % 4 == 2) ? 16'(-50) : 16'd100;
        send_frame(bias, 1'b0);
        send_random_class_set();
    endtask

    task automatic random_frame_with_gaps();
        bias_word_t bias;
        fill_random_frame(bias);
        send_frame(bias, 1'b1);
    endtask

    // Classes 2, 5 and 8 tie at the top
    task automatic classify_with_tie();
        int         raw_v [NUM_CLASSES];
        int         bias_v [NUM_CLASSES];
        score_vec_t raw;
        bias_word_t bias;
        raw_v  = '{-200, 50, 300, -5, 120, 300, 10, -1000, 280, 20};
        bias_v = '{0, 10, 5, 0, 0, 5, 0, 0, 25, -30};
        bias   = '0;
        for (int k = 0; k < NUM_CLASSES; k++)
        begin
            raw[k]  = DATA_W'(raw_v[k]);
            bias[k] = DATA_W'(bias_v[k]);
        end
        send_class_set(raw, bias);
    endtask

    task automatic back_to_back_frames();
        bias_word_t bias;
        score_vec_t raw;
        fill_random_frame(bias);
        send_frame(bias, 1'b0);
        for (int k = 0; k < NUM_CLASSES; k++)
            raw[k] = DATA_W'(-100 - 7 * k);
        send_class_set(raw, '0);
        fill_random_frame(bias);
        send_frame(bias, 1'b0);
        send_random_class_set();
    endtask

    // Cycle count and comparison of every write and digit
    always @(negedge clk)
    begin : monitor
        fmap_wr_t w;
        cycle = cycle + 1;
        if (cycle > TIMEOUT)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            end_with_failure();
        end
        else if (rst === 1'b0)
        begin
            if (phase_pending)
                check("conv_phase_o", conv_phase, 1'b0);
            phase_pending = 1'b0;
            if (fmap_wr.en && exp_wr.size() == 0)
            begin
                $display("unexpected fmap write to address %0d", fmap_wr.addr);
                end_with_failure();
            end
            else if (fmap_wr.en)
            begin
                w = exp_wr.pop_front();
                check("fmap_wr_o.addr", fmap_wr.addr, w.addr);
                check("fmap_wr_o.data", fmap_wr.data, w.data);
                wr_count = wr_count + 1;
                // Phase must drop one cycle after the last write of a frame
                if (wr_count % POOLED == 0)
                begin
                    check("conv_phase_o", conv_phase, 1'b1);
                    phase_pending = 1'b1;
                end
            end
            if (digit.valid && exp_digit.size() == 0)
            begin
                $display("digit_o.valid was high with no classification pending");
                end_with_failure();
            end
            else if (digit.valid)
            begin
                check("digit_o.digit", digit.digit, exp_digit.pop_front());
                check("digit_o.valid cycle", cycle, digit_due.pop_front());
            end
        end
    end

    initial
    begin
        rst  = 1'b1;
        mac  = '0;
        seed = 32'hcd03;
        for (int a = 0; a < (1 << BIAS_ADDR_W); a++)
        begin
            for (int k = 0; k < NUM_CH; k++)
                bias_rom[a][k] = DATA_W'(a * 256 + k);
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        verify_reset_state();
        constant_frame_writes();
        relu_pool_extremes();
        random_frame_with_gaps();
        classify_with_tie();
        back_to_back_frames();
        for (int i = 0; i < 20 && (exp_wr.size() != 0 || exp_digit.size() != 0); i++)
            @(posedge clk);
        if (exp_wr.size() != 0 || exp_digit.size() != 0)
        begin
            $display("expected outputs never appeared: %0d writes, %0d digits",
                     exp_wr.size(), exp_digit.size());
            end_with_failure();
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+sim
source/cnn_rx_pkg.sv
source/rx_sequencer.sv
source/pool_window.sv
source/score_bank.sv
source/argmax_tree.sv
source/cnn_receiver.sv
sim/tb_cnn_receiver.sv

// ==== Bender.yml ====
package:
  name: cnn_receiver

sources:
  - source/cnn_rx_pkg.sv
  - source/rx_sequencer.sv
  - source/pool_window.sv
  - source/score_bank.sv
  - source/argmax_tree.sv
  - source/cnn_receiver.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cnn_receiver.sv
